//--- hdl/ip_hdr_pkg.sv
// IPv4 header field types, header layout and protocol constants shared by RTL and the test model
package ip_hdr_pkg;

    // fixed header shape without options
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;
    localparam int IP_HDR_BYTES = 20;
    localparam int IP_HDR_HALFWORDS = 10;

    // byte positions of the header checksum on the wire
    localparam int IP_CSUM_BYTE_HI = 10;
    localparam int IP_CSUM_BYTE_LO = 11;

    typedef logic [31:0] ip_addr_t;
    typedef logic [5:0] ip_dscp_t;
    typedef logic [1:0] ip_ecn_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [15:0] ip_id_t;
    typedef logic [2:0] ip_flags_t;
    typedef logic [12:0] ip_frag_t;
    typedef logic [7:0] ip_ttl_t;
    typedef logic [7:0] ip_proto_t;
    typedef logic [15:0] ip_csum_t;

    // fields in transmission order with the msb first
    typedef struct packed {
        logic [3:0] version;
        logic [3:0] ihl;
        ip_dscp_t   dscp;
        ip_ecn_t    ecn;
        ip_len_t    total_length;
        ip_id_t     identification;
        ip_flags_t  flags;
        ip_frag_t   fragment_offset;
        ip_ttl_t    ttl;
        ip_proto_t  protocol;
        ip_csum_t   checksum;
        ip_addr_t   source;
        ip_addr_t   destination;
    } ip_hdr_t;

    // same 160 bits seen as fields, wire bytes or checksum halfwords
    typedef union packed {
        ip_hdr_t                            hdr;
        logic [0:IP_HDR_BYTES-1][7:0]       bytes;
        logic [0:IP_HDR_HALFWORDS-1][15:0]  halfwords;
    } ip_hdr_u;

endpackage

//--- hdl/ip_tx_pkg.sv
// framer implementation types, the FSM state encoding and the stream and counter widths
package ip_tx_pkg;

    // framer FSM
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_HEADER  = 2'd1,
        ST_PAYLOAD = 2'd2
    } tx_state_t;

    // index into the 20 header bytes
    typedef logic [4:0] hdr_ptr_t;

    // one stream byte
    typedef logic [7:0] byte_t;

endpackage

//--- hdl/ip_byte_if.sv
// byte stream link from the framer into the output skid buffer with producer and buffer views
`timescale 1ns/1ps

interface ip_byte_if;
    import ip_tx_pkg::*;

    byte_t data;
    logic  valid;
    logic  last;
    logic  user;
    // registered in the buffer so the framer sees it one cycle early
    logic  ready;

    modport producer (
        output data,
        output valid,
        output last,
        output user,
        input  ready
    );

    modport buffer (
        input  data,
        input  valid,
        input  last,
        input  user,
        output ready
    );

endinterface

//--- hdl/ip_hdr_checksum.sv
// combinational IPv4 header checksum over the captured header with its checksum field zero
`timescale 1ns/1ps

module ip_hdr_checksum (
    input  ip_hdr_pkg::ip_hdr_u  hdr,
    output ip_hdr_pkg::ip_csum_t csum
);
    import ip_hdr_pkg::*;

    logic [16:0] acc;
    ip_csum_t    sum;

    // ones' complement sum of the ten halfwords
    always_comb begin
        sum = '0;
        acc = '0;
        for (int i = 0; i < IP_HDR_HALFWORDS; i++) begin
            acc = {1'b0, sum} + {1'b0, hdr.halfwords[i]};
            // end-around carry that cannot overflow a second time
            sum = acc[15:0] + {15'd0, acc[16]};
        end
    end

    assign csum = ~sum;

endmodule

//--- hdl/ip_tx_framer.sv
// IPv4 framer that captures a header, sends its 20 bytes, then forwards and length-checks payload
`timescale 1ns/1ps

module ip_tx_framer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       hdr_valid,
    output logic                       hdr_ready,
    input  ip_hdr_pkg::ip_dscp_t       dscp,
    input  ip_hdr_pkg::ip_ecn_t        ecn,
    input  ip_hdr_pkg::ip_len_t        ip_length,
    input  ip_hdr_pkg::ip_id_t         identification,
    input  ip_hdr_pkg::ip_flags_t      flags,
    input  ip_hdr_pkg::ip_frag_t       fragment_offset,
    input  ip_hdr_pkg::ip_ttl_t        ttl,
    input  ip_hdr_pkg::ip_proto_t      protocol,
    input  ip_hdr_pkg::ip_addr_t       source_ip,
    input  ip_hdr_pkg::ip_addr_t       dest_ip,
    output ip_hdr_pkg::ip_hdr_u        hdr,
    input  ip_hdr_pkg::ip_csum_t       csum,
    input  ip_tx_pkg::byte_t           pl_data,
    input  logic                       pl_valid,
    output logic                       pl_ready,
    input  logic                       pl_last,
    input  logic                       pl_user,
    ip_byte_if.producer                out,
    output logic                       busy,
    output logic                       error_payload_early_termination
);
    import ip_hdr_pkg::*;
    import ip_tx_pkg::*;

    tx_state_t state_q;
    tx_state_t state_d;
    hdr_ptr_t  hdr_ptr_q;
    hdr_ptr_t  hdr_ptr_d;
    ip_len_t   pl_cnt_q;
    ip_len_t   pl_cnt_d;
    ip_hdr_u   hdr_q;
    logic      hdr_ready_q;
    logic      busy_q;
    logic      err_q;
    logic      err_d;
    logic      hdr_take;
    logic      pl_take;

    assign hdr_take = hdr_valid && hdr_ready_q;

    // payload flows only while the buffer can take it
    assign pl_ready = (state_q == ST_PAYLOAD) && out.ready;
    assign pl_take = pl_valid && pl_ready;

    assign hdr_ready = hdr_ready_q;
    assign hdr = hdr_q;
    assign busy = busy_q;
    assign error_payload_early_termination = err_q;

    always_comb begin
        state_d = state_q;
        hdr_ptr_d = hdr_ptr_q;
        pl_cnt_d = pl_cnt_q;
        err_d = 1'b0;
        out.valid = 1'b0;
        out.data = '0;
        out.last = 1'b0;
        out.user = 1'b0;

        case (state_q)
            ST_IDLE: begin
                hdr_ptr_d = '0;
                if (hdr_take) begin
                    // payload bytes still owed after the fixed header
                    pl_cnt_d = ip_length - ip_len_t'(IP_HDR_BYTES);
                    state_d = ST_HEADER;
                end
            end
            ST_HEADER: begin
                if (out.ready) begin
                    out.valid = 1'b1;
                    if (hdr_ptr_q == hdr_ptr_t'(IP_CSUM_BYTE_HI)) begin
                        out.data = csum[15:8];
                    end else if (hdr_ptr_q == hdr_ptr_t'(IP_CSUM_BYTE_LO)) begin
                        out.data = csum[7:0];
                    end else begin
                        out.data = hdr_q.bytes[hdr_ptr_q];
                    end
                    hdr_ptr_d = hdr_ptr_q + hdr_ptr_t'(1);
                    if (hdr_ptr_q == hdr_ptr_t'(IP_HDR_BYTES - 1)) begin
                        state_d = ST_PAYLOAD;
                    end
                end
            end
            ST_PAYLOAD: begin
                out.data = pl_data;
                out.last = pl_last;
                out.user = pl_user;
                if (pl_take) begin
                    out.valid = 1'b1;
                    // stops at zero so an over-long payload is not flagged
                    if (pl_cnt_q != '0) begin
                        pl_cnt_d = pl_cnt_q - ip_len_t'(1);
                    end
                    if (pl_last) begin
                        // frame ended before the declared length
                        if (pl_cnt_q > 16'd1) begin
                            out.user = 1'b1;
                            err_d = 1'b1;
                        end
                        state_d = ST_IDLE;
                    end
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            hdr_ptr_q <= '0;
            pl_cnt_q <= '0;
            hdr_ready_q <= 1'b0;
            busy_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            state_q <= state_d;
            hdr_ptr_q <= hdr_ptr_d;
            pl_cnt_q <= pl_cnt_d;
            hdr_ready_q <= (state_d == ST_IDLE);
            busy_q <= (state_d != ST_IDLE);
            err_q <= err_d;
        end
    end

    // header store with the checksum field left zero for the summing unit
    always_ff @(posedge clk) begin
        if (hdr_take) begin
            hdr_q.hdr.version <= IP_VERSION;
            hdr_q.hdr.ihl <= IP_IHL;
            hdr_q.hdr.dscp <= dscp;
            hdr_q.hdr.ecn <= ecn;
            hdr_q.hdr.total_length <= ip_length;
            hdr_q.hdr.identification <= identification;
            hdr_q.hdr.flags <= flags;
            hdr_q.hdr.fragment_offset <= fragment_offset;
            hdr_q.hdr.ttl <= ttl;
            hdr_q.hdr.protocol <= protocol;
            hdr_q.hdr.checksum <= '0;
            hdr_q.hdr.source <= source_ip;
            hdr_q.hdr.destination <= dest_ip;
        end
    end

endmodule

//--- hdl/axis_skid_buffer.sv
// two-entry output register stage that drives the stream pins and hands a registered ready back
`timescale 1ns/1ps

module axis_skid_buffer (
    input  logic             clk,
    input  logic             rst_n,
    ip_byte_if.buffer        in,
    output ip_tx_pkg::byte_t tx_data,
    output logic             tx_valid,
    input  logic             tx_ready,
    output logic             tx_last,
    output logic             tx_user
);
    import ip_tx_pkg::*;

    byte_t out_data_q;
    logic  out_valid_q;
    logic  out_valid_d;
    logic  out_last_q;
    logic  out_user_q;
    byte_t tmp_data_q;
    logic  tmp_valid_q;
    logic  tmp_valid_d;
    logic  tmp_last_q;
    logic  tmp_user_q;
    logic  ready_q;
    logic  ready_early;
    logic  in_to_out;
    logic  in_to_tmp;
    logic  tmp_to_out;

    // next-cycle ready when the sink takes data or nothing is held
    assign ready_early = tx_ready || (!tmp_valid_q && !out_valid_q);
    assign in.ready = ready_q;

    assign tx_data = out_data_q;
    assign tx_valid = out_valid_q;
    assign tx_last = out_last_q;
    assign tx_user = out_user_q;

    always_comb begin
        out_valid_d = out_valid_q;
        tmp_valid_d = tmp_valid_q;
        in_to_out = 1'b0;
        in_to_tmp = 1'b0;
        tmp_to_out = 1'b0;
        if (ready_q) begin
            if (tx_ready || !out_valid_q) begin
                out_valid_d = in.valid;
                in_to_out = 1'b1;
            end else begin
                // park the arriving byte while the output is stalled
                tmp_valid_d = in.valid;
                in_to_tmp = 1'b1;
            end
        end else if (tx_ready) begin
            out_valid_d = tmp_valid_q;
            tmp_valid_d = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
            out_valid_q <= 1'b0;
            tmp_valid_q <= 1'b0;
        end else begin
            ready_q <= ready_early;
            out_valid_q <= out_valid_d;
            tmp_valid_q <= tmp_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_data_q <= in.data;
            out_last_q <= in.last;
            out_user_q <= in.user;
        end else if (tmp_to_out) begin
            out_data_q <= tmp_data_q;
            out_last_q <= tmp_last_q;
            out_user_q <= tmp_user_q;
        end
        if (in_to_tmp) begin
            tmp_data_q <= in.data;
            tmp_last_q <= in.last;
            tmp_user_q <= in.user;
        end
    end

endmodule

//--- hdl/ip_tx_top.sv
// top level of the IPv4 transmit framer with plain header, payload and stream ports
`timescale 1ns/1ps

module ip_tx_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hdr_valid,
    output logic                   hdr_ready,
    input  ip_hdr_pkg::ip_dscp_t   dscp,
    input  ip_hdr_pkg::ip_ecn_t    ecn,
    input  ip_hdr_pkg::ip_len_t    ip_length,
    input  ip_hdr_pkg::ip_id_t     identification,
    input  ip_hdr_pkg::ip_flags_t  flags,
    input  ip_hdr_pkg::ip_frag_t   fragment_offset,
    input  ip_hdr_pkg::ip_ttl_t    ttl,
    input  ip_hdr_pkg::ip_proto_t  protocol,
    input  ip_hdr_pkg::ip_addr_t   source_ip,
    input  ip_hdr_pkg::ip_addr_t   dest_ip,
    input  ip_tx_pkg::byte_t       pl_data,
    input  logic                   pl_valid,
    output logic                   pl_ready,
    input  logic                   pl_last,
    input  logic                   pl_user,
    output ip_tx_pkg::byte_t       tx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output logic                   tx_last,
    output logic                   tx_user,
    output logic                   busy,
    output logic                   error_payload_early_termination
);
    import ip_hdr_pkg::*;

    ip_hdr_u  hdr_w;
    ip_csum_t csum_w;

    ip_byte_if byte_if ();

    ip_tx_framer framer_i (
        .clk                             (clk),
        .rst_n                           (rst_n),
        .hdr_valid                       (hdr_valid),
        .hdr_ready                       (hdr_ready),
        .dscp                            (dscp),
        .ecn                             (ecn),
        .ip_length                       (ip_length),
        .identification                  (identification),
        .flags                           (flags),
        .fragment_offset                 (fragment_offset),
        .ttl                             (ttl),
        .protocol                        (protocol),
        .source_ip                       (source_ip),
        .dest_ip                         (dest_ip),
        .hdr                             (hdr_w),
        .csum                            (csum_w),
        .pl_data                         (pl_data),
        .pl_valid                        (pl_valid),
        .pl_ready                        (pl_ready),
        .pl_last                         (pl_last),
        .pl_user                         (pl_user),
        .out                             (byte_if.producer),
        .busy                            (busy),
        .error_payload_early_termination (error_payload_early_termination)
    );

    ip_hdr_checksum checksum_i (
        .hdr  (hdr_w),
        .csum (csum_w)
    );

    axis_skid_buffer skid_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (byte_if.buffer),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx_last  (tx_last),
        .tx_user  (tx_user)
    );

endmodule

//--- dv/ip_tx_assertions.sv
// concurrent protocol checks on the framer top level that the testbench attaches by bind
`timescale 1ns/1ps

module ip_tx_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic             hdr_ready,
    input logic             busy,
    input logic             error_payload_early_termination,
    input ip_tx_pkg::byte_t tx_data,
    input logic             tx_valid,
    input logic             tx_ready,
    input logic             tx_last,
    input logic             tx_user
);

    // a stalled byte keeps its value and marks until taken
    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_valid && !tx_ready) |=>
            (tx_valid && $stable(tx_data) && $stable(tx_last) && $stable(tx_user)))
    else $error("tx stream changed while stalled");

    // no new header while a frame is in progress
    hdr_blocked_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !hdr_ready)
    else $error("hdr_ready high while busy");

    // output flops clear asynchronously within the first half cycle of reset
    reset_quiet: assert property (@(negedge clk)
        !rst_n |-> !tx_valid)
    else $error("tx_valid high during reset");

    err_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        error_payload_early_termination |=> !error_payload_early_termination)
    else $error("early termination error held for two cycles");

endmodule

//--- dv/tb_ip_tx.sv
// random-stimulus testbench for the IPv4 framer top level that the Makefile builds and runs
`timescale 1ns/1ps

module tb_ip_tx;
    import ip_hdr_pkg::*;
    import ip_tx_pkg::*;

    localparam logic [31:0] SEED = 32'h99dc_a1ba;
    localparam int N_FRAMES = 40;
    localparam int TIMEOUT_CYCLES = N_FRAMES * 60 * 4 + 1000;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      hdr_valid = 1'b0;
    ip_dscp_t  dscp = '0;
    ip_ecn_t   ecn = '0;
    ip_len_t   ip_length = '0;
    ip_id_t    identification = '0;
    ip_flags_t flags = '0;
    ip_frag_t  fragment_offset = '0;
    ip_ttl_t   ttl = '0;
    ip_proto_t protocol = '0;
    ip_addr_t  source_ip = '0;
    ip_addr_t  dest_ip = '0;
    byte_t     pl_data = '0;
    logic      pl_valid = 1'b0;
    logic      pl_last = 1'b0;
    logic      pl_user = 1'b0;
    logic      tx_ready = 1'b0;
    logic      hdr_ready;
    logic      pl_ready;
    byte_t     tx_data;
    logic      tx_valid;
    logic      tx_last;
    logic      tx_user;
    logic      busy;
    logic      error_payload_early_termination;

    // expected output bytes as {user, last, data}
    logic [9:0]  exp_q [$];
    logic [9:0]  exp_item;
    logic [31:0] stim_state = SEED;
    logic [31:0] sink_state = SEED ^ 32'h0f0f_0f0f;
    string       test_name;
    int          out_pos = 0;
    int          mon_errs = 0;
    int          main_errs = 0;
    int          err_pulses = 0;
    int          short_frames = 0;
    int          cycles = 0;

    ip_tx_top ip_tx_top_i (.*);

    bind ip_tx_top ip_tx_assertions assertions_i (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    task automatic finish_run(input logic timed_out);
        $display("error counts: output %0d, control %0d, timeout %0d",
                 mon_errs, main_errs, timed_out);
        if (timed_out || mon_errs != 0 || main_errs != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    endtask

    // builds one frame, queues its expected bytes, then drives header and payload
    task automatic send_frame();
        logic [7:0]  hb [IP_HDR_BYTES];
        logic [7:0]  pd [$];
        logic        pu [$];
        logic [31:0] r_a;
        logic [31:0] r_b;
        logic [31:0] r_src;
        logic [31:0] r_dst;
        logic [31:0] r;
        logic [31:0] sum;
        logic [15:0] len;
        logic        short_frame;
        logic        is_last;
        int          n_decl;
        int          n_sent;
        int          cut;
        int          idx;

        r_a = next_stim();
        r_b = next_stim();
        r_src = next_stim();
        r_dst = next_stim();
        n_decl = 1 + int'(r_b[28:24]);
        len = 16'(IP_HDR_BYTES + n_decl);
        r = next_stim();
        short_frame = (r[1:0] == 2'd0) && (n_decl >= 2);
        cut = 1 + int'(r[9:8]) % 3;
        if (cut > n_decl - 1) begin
            cut = n_decl - 1;
        end
        n_sent = short_frame ? n_decl - cut : n_decl;
        if (short_frame) begin
            short_frames++;
        end

        // wire order of the fixed 20-byte header
        hb[0] = {IP_VERSION, IP_IHL};
        hb[1] = {r_a[5:0], r_a[7:6]};
        hb[2] = len[15:8];
        hb[3] = len[7:0];
        hb[4] = r_a[23:16];
        hb[5] = r_a[15:8];
        hb[6] = {r_b[2:0], r_b[15:11]};
        hb[7] = r_b[10:3];
        hb[8] = r_a[31:24];
        hb[9] = r_b[23:16];
        hb[IP_CSUM_BYTE_HI] = 8'h00;
        hb[IP_CSUM_BYTE_LO] = 8'h00;
        for (idx = 0; idx < 4; idx++) begin
            hb[12 + idx] = r_src[31 - 8 * idx -: 8];
            hb[16 + idx] = r_dst[31 - 8 * idx -: 8];
        end
        // plain 32-bit sum with the carries folded back at the end
        sum = '0;
        for (idx = 0; idx < IP_HDR_HALFWORDS; idx++) begin
            sum = sum + {16'd0, hb[2 * idx], hb[2 * idx + 1]};
        end
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
        hb[IP_CSUM_BYTE_HI] = ~sum[15:8];
        hb[IP_CSUM_BYTE_LO] = ~sum[7:0];

        for (idx = 0; idx < n_sent; idx++) begin
            r = next_stim();
            pd.push_back(r[7:0]);
            pu.push_back(r[10:8] == 3'd0);
        end
        for (idx = 0; idx < IP_HDR_BYTES; idx++) begin
            exp_q.push_back({2'b00, hb[idx]});
        end
        for (idx = 0; idx < n_sent; idx++) begin
            is_last = (idx == n_sent - 1);
            exp_q.push_back({pu[idx] | (short_frame && is_last), is_last, pd[idx]});
        end

        @(posedge clk);
        hdr_valid <= 1'b1;
        dscp <= r_a[5:0];
        ecn <= r_a[7:6];
        identification <= r_a[23:8];
        ttl <= r_a[31:24];
        flags <= r_b[2:0];
        fragment_offset <= r_b[15:3];
        protocol <= r_b[23:16];
        ip_length <= len;
        source_ip <= r_src;
        dest_ip <= r_dst;
        @(negedge clk);
        while (!hdr_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        hdr_valid <= 1'b0;

        idx = 0;
        while (idx < n_sent) begin
            @(posedge clk);
            r = next_stim();
            if (r[1:0] == 2'd0) begin
                pl_valid <= 1'b0;
            end else begin
                pl_valid <= 1'b1;
                pl_data <= pd[idx];
                pl_last <= (idx == n_sent - 1);
                pl_user <= pu[idx];
                @(negedge clk);
                while (!pl_ready) begin
                    @(negedge clk);
                end
                idx++;
            end
        end
        @(posedge clk);
        pl_valid <= 1'b0;
        pl_last <= 1'b0;
    endtask

    // sink with random stalls
    always @(posedge clk) begin
        if (rst_n) begin
            sink_state = xorshift32(sink_state);
            tx_ready <= (sink_state[1:0] != 2'b00);
        end
    end

    always @(negedge clk) begin
        if (rst_n && tx_valid && tx_ready) begin
            if (exp_q.size() == 0) begin
                mon_errs++;
                $display("output byte %02h appeared with no byte expected", tx_data);
            end else begin
                exp_item = exp_q.pop_front();
                test_name = (out_pos < IP_HDR_BYTES) ? "header_bytes" : "payload";
                if (tx_data !== exp_item[7:0]) begin
                    mon_errs++;
                    $display("ERR %s pos %0d: expected %02h actual %02h",
                             test_name, out_pos, exp_item[7:0], tx_data);
                end
                if (tx_last !== exp_item[8]) begin
                    mon_errs++;
                    $display("ERR %s tx_last pos %0d: expected %0b actual %0b",
                             test_name, out_pos, exp_item[8], tx_last);
                end
                if (tx_user !== exp_item[9]) begin
                    mon_errs++;
                    $display("ERR %s tx_user pos %0d: expected %0b actual %0b",
                             test_name, out_pos, exp_item[9], tx_user);
                end
            end
            out_pos = tx_last ? 0 : out_pos + 1;
        end
    end

    always @(negedge clk) begin
        if (rst_n && error_payload_early_termination) begin
            err_pulses++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: frames still in flight after %0d cycles", cycles);
            finish_run(1'b1);
        end
    end

    initial begin
        int frame_idx;
        for (frame_idx = 0; frame_idx < 16; frame_idx++) begin
            @(negedge clk);
            if (hdr_ready || pl_ready || tx_valid || busy) begin
                main_errs++;
                $display("an output that must be low is high during reset");
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;

        for (frame_idx = 0; frame_idx < N_FRAMES; frame_idx++) begin
            send_frame();
        end

        // let the last frame drain out of the buffer
        while (exp_q.size() != 0 || busy) begin
            @(negedge clk);
        end
        @(negedge clk);
        if (busy || !hdr_ready) begin
            main_errs++;
            $display("framer is not idle with hdr_ready high after the last frame");
        end
        if (err_pulses != short_frames) begin
            main_errs++;
            $display("ERR short_payload: expected %0d pulses actual %0d",
                     short_frames, err_pulses);
        end
        finish_run(1'b0);
    end

endmodule

//--- verilog.f
hdl/ip_hdr_pkg.sv
hdl/ip_tx_pkg.sv
hdl/ip_byte_if.sv
hdl/ip_hdr_checksum.sv
hdl/ip_tx_framer.sv
hdl/axis_skid_buffer.sv
hdl/ip_tx_top.sv
dv/ip_tx_assertions.sv
dv/tb_ip_tx.sv

//--- Makefile
# Verilator flow for the IPv4 transmit framer

VERILATOR ?= verilator
TOP       ?= tb_ip_tx
RTL_TOP   ?= ip_tx_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter hdl/%,$(SRCS))
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
